// ==== design/coco_pkg.sv ====
// coco bus glue definitions
package coco_pkg;

  // decoded bus device, one per chip select on the board
  typedef enum logic [3:0] {
    DEV_RAM    = 4'd0,  // 32k dynamic ram
    DEV_ROM_LO = 4'd1,  // extended basic at 8000
    DEV_ROM_HI = 4'd2,  // color basic at a000, plus vectors
    DEV_CART   = 4'd3,  // cartridge slot
    DEV_PIA0   = 4'd4,  // keyboard / joystick pia
    DEV_PIA1   = 4'd5,  // dac / vdg control pia
    DEV_ACIA   = 4'd6,  // dragon 64 serial, shares pia0 space
    DEV_IO     = 4'd7,  // disk controller window
    DEV_NONE   = 4'd8   // unmapped, reads float high
  } device_e;

  // memory map bounds
  localparam logic [15:0] RAM_END     = 16'h7FFF;
  localparam logic [15:0] ROM_LO_BASE = 16'h8000;
  localparam logic [15:0] ROM_HI_BASE = 16'hA000;
  localparam logic [15:0] CART_BASE   = 16'hC000;
  localparam logic [15:0] IO_PAGE     = 16'hFF00;  // pia0 starts here
  localparam logic [15:0] PIA1_BASE   = 16'hFF20;
  localparam logic [15:0] IO_BASE     = 16'hFF40;  // fdc window
  localparam logic [15:0] IO_END      = 16'hFF5F;
  localparam logic [15:0] VECTOR_BASE = 16'hFFF0;  // 6809 vectors, mirrored from rom

  // system clock enable divisors
  // normal ~14.3 mhz from 42.9, turbo ~21.5 mhz
  localparam int CLK_DIV_NORMAL = 3;
  localparam int CLK_DIV_TURBO  = 2;

  // digital pad axis positions
  localparam logic [7:0] JOY_CENTER = 8'd128;
  localparam logic [7:0] JOY_LOW    = 8'd16;   // left / up
  localparam logic [7:0] JOY_HIGH   = 8'd240;  // right / down

  // value seen on an undriven data bus
  localparam logic [7:0] OPEN_BUS = 8'hFF;

endpackage

// ==== design/clock_enable_gen.sv ====
// system clock enable divider
`timescale 1ns/1ps

module clock_enable_gen
  import coco_pkg::*;
(
  input  logic clk,
  input  logic reset_n,
  input  logic turbo,    // divide by 2 instead of 3
  output logic clk_ena   // one cycle pulse
);

  logic [1:0] div_cnt;
  logic [1:0] div_wrap;  // last count before the pulse

  // picked every cycle, so a turbo change lands at the next wrap
  assign div_wrap = turbo ? 2'(CLK_DIV_TURBO - 1) : 2'(CLK_DIV_NORMAL - 1);

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      div_cnt <= 2'd0;
      clk_ena <= 1'b0;
    end
    else if (div_cnt >= div_wrap)  // >= covers a switch into turbo at count 2
    begin
      div_cnt <= 2'd0;
      clk_ena <= 1'b1;
    end
    else
    begin
      div_cnt <= div_cnt + 2'd1;
      clk_ena <= 1'b0;
    end
  end

  // smallest divisor is 2, so pulses never touch
  a_ena_single_cycle: assert property (
    @(posedge clk) disable iff (!reset_n)
    clk_ena |=> !clk_ena
  );

endmodule

// ==== design/address_decoder.sv ====
// 6809 memory map decoder
`timescale 1ns/1ps

module address_decoder
  import coco_pkg::*;
(
  input  logic [15:0] cpu_addr,
  input  logic        dragon64,  // enables acia split and rom banking
  input  logic        ddrb2,     // pia1 ddrb bit 2
  input  logic        portb2,    // pia1 port b bit 2
  output device_e     device,
  output logic        alt_bank   // dragon 64 second rom chip
);

  logic in_ff_page;  // ff00 and up is handled piecewise
  logic is_rom;
  logic bank_pin;    // state of the bank select line

  assign in_ff_page = (cpu_addr >= IO_PAGE);

  always_comb
  begin
    device = DEV_NONE;  // unmapped holes in the ff page
    if (cpu_addr <= RAM_END)
    begin
      device = DEV_RAM;
    end
    else if (cpu_addr >= ROM_LO_BASE && cpu_addr < ROM_HI_BASE)
    begin
      device = DEV_ROM_LO;
    end
    else if (cpu_addr >= ROM_HI_BASE && cpu_addr < CART_BASE)
    begin
      device = DEV_ROM_HI;
    end
    else if (!in_ff_page)
    begin
      device = DEV_CART;  // c000..feff
    end
    else if (cpu_addr < PIA1_BASE)
    begin
      // dragon 64 hangs the acia on a2 inside the pia0 block
      if (dragon64 && cpu_addr[2])
        device = DEV_ACIA;
      else
        device = DEV_PIA0;
    end
    else if (cpu_addr < IO_BASE)
    begin
      device = DEV_PIA1;
    end
    else if (cpu_addr <= IO_END)
    begin
      device = DEV_IO;  // ff40..ff5f
    end
    else if (cpu_addr >= VECTOR_BASE)
    begin
      device = DEV_ROM_HI;  // vectors come from the top of basic
    end
  end

  assign is_rom = (device == DEV_ROM_LO) || (device == DEV_ROM_HI);

  // port b bit 2 has a pull-up, so the bank only flips when it is
  // driven as an output and held low
  assign bank_pin = ddrb2 && !portb2;

  assign alt_bank = dragon64 && is_rom && bank_pin;

endmodule

// ==== design/read_data_mux.sv ====
// cpu read data select and latch
`timescale 1ns/1ps

module read_data_mux
  import coco_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       clk_ena,     // system clock enable
  input  logic       bus_sample,  // cpu wants data this enable
  input  device_e    device,
  input  logic       alt_bank,
  input  logic [7:0] ram_data,
  input  logic [7:0] rom_lo_data,
  input  logic [7:0] rom_lo_alt_data,
  input  logic [7:0] rom_hi_data,
  input  logic [7:0] rom_hi_alt_data,
  input  logic [7:0] cart_data,
  input  logic [7:0] pia0_data,
  input  logic [7:0] pia1_data,
  input  logic [7:0] acia_data,
  input  logic [7:0] io_data,
  output logic [7:0] cpu_din
);

  logic [7:0] sel_data;  // byte on the bus this cycle
  logic       sample;

  always_comb
  begin
    case (device)
      DEV_RAM:    sel_data = ram_data;
      DEV_ROM_LO: sel_data = alt_bank ? rom_lo_alt_data : rom_lo_data;
      DEV_ROM_HI: sel_data = alt_bank ? rom_hi_alt_data : rom_hi_data;
      DEV_CART:   sel_data = cart_data;
      DEV_PIA0:   sel_data = pia0_data;
      DEV_PIA1:   sel_data = pia1_data;
      DEV_ACIA:   sel_data = acia_data;
      DEV_IO:     sel_data = io_data;
      default:    sel_data = OPEN_BUS;  // DEV_NONE, bus floats
    endcase
  end

  assign sample = clk_ena && bus_sample;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      cpu_din <= OPEN_BUS;
    else if (sample)
      cpu_din <= sel_data;  // held until the next sample
  end

  // decoder must hand over a real device code whenever a read is taken
  a_device_defined: assert property (
    @(posedge clk) disable iff (!reset_n)
    bus_sample |-> device inside {DEV_RAM, DEV_ROM_LO, DEV_ROM_HI, DEV_CART,
                                  DEV_PIA0, DEV_PIA1, DEV_ACIA, DEV_IO, DEV_NONE}
  );

  // alternate bank only exists for the two rom chips
  a_alt_bank_rom_only: assert property (
    @(posedge clk) disable iff (!reset_n)
    alt_bank |-> (device == DEV_ROM_LO || device == DEV_ROM_HI)
  );

endmodule

// ==== design/joystick_dac_compare.sv ====
// joystick axis compare against dac
`timescale 1ns/1ps

module joystick_dac_compare
  import coco_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        joy_use_dpad,  // digital pad instead of analog sticks
  input  logic [3:0]  joy1,          // right, left, down, up
  input  logic [3:0]  joy2,
  input  logic [15:0] joya1,         // x in high byte, y in low byte
  input  logic [15:0] joya2,
  input  logic [5:0]  dac_data,      // 6-bit dac from pia1 port a
  input  logic        sela,
  input  logic        selb,
  output logic        hilo           // axis at or above the dac level
);

  logic [7:0] joy1_x;
  logic [7:0] joy1_y;
  logic [7:0] joy2_x;
  logic [7:0] joy2_y;
  logic [7:0] axis_sel;   // axis routed to the comparator
  logic [7:0] dac_level;  // dac scaled to the 8-bit axis range

  // one pad axis, the negative direction wins a double press
  function automatic logic [7:0] pad_axis(input logic pos, input logic neg);
    logic [7:0] val;
    val = JOY_CENTER;
    if (pos)
      val = JOY_HIGH;
    if (neg)
      val = JOY_LOW;
    return val;
  endfunction

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      joy1_x <= JOY_CENTER;
      joy1_y <= JOY_CENTER;
      joy2_x <= JOY_CENTER;
      joy2_y <= JOY_CENTER;
    end
    else if (joy_use_dpad)
    begin
      joy1_x <= pad_axis(joy1[0], joy1[1]);  // right / left
      joy1_y <= pad_axis(joy1[2], joy1[3]);  // down / up
      joy2_x <= pad_axis(joy2[0], joy2[1]);
      joy2_y <= pad_axis(joy2[2], joy2[3]);
    end
    else
    begin
      joy1_x <= joya1[15:8];
      joy1_y <= joya1[7:0];
      joy2_x <= joya2[15:8];
      joy2_y <= joya2[7:0];
    end
  end

  // sela/selb come from the pia0 ca2/cb2 lines
  always_comb
  begin
    case ({selb, sela})
      2'b00:   axis_sel = joy1_x;
      2'b01:   axis_sel = joy1_y;
      2'b10:   axis_sel = joy2_x;
      default: axis_sel = joy2_y;
    endcase
  end

  assign dac_level = {dac_data, 2'b00};
  assign hilo      = (axis_sel >= dac_level);  // software does a binary search on this

endmodule

// ==== design/coco_bus_glue.sv ====
// coco bus glue top
`timescale 1ns/1ps

module coco_bus_glue
  import coco_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        turbo,
  input  logic        dragon64,
  input  logic [15:0] cpu_addr,
  input  logic        ddrb2,
  input  logic        portb2,
  input  logic        bus_sample,
  input  logic [7:0]  ram_data,
  input  logic [7:0]  rom_lo_data,
  input  logic [7:0]  rom_lo_alt_data,
  input  logic [7:0]  rom_hi_data,
  input  logic [7:0]  rom_hi_alt_data,
  input  logic [7:0]  cart_data,
  input  logic [7:0]  pia0_data,
  input  logic [7:0]  pia1_data,
  input  logic [7:0]  acia_data,
  input  logic [7:0]  io_data,
  input  logic        joy_use_dpad,
  input  logic [3:0]  joy1,
  input  logic [3:0]  joy2,
  input  logic [15:0] joya1,
  input  logic [15:0] joya2,
  input  logic [5:0]  dac_data,
  input  logic        sela,
  input  logic        selb,
  output logic        clk_ena,
  output device_e     device_sel,
  output logic [7:0]  cpu_din,
  output logic        hilo
);

  logic alt_bank;  // decoder to mux

  clock_enable_gen i_clock_enable_gen (
    .clk     (clk),
    .reset_n (reset_n),
    .turbo   (turbo),
    .clk_ena (clk_ena)
  );

  address_decoder i_address_decoder (
    .cpu_addr (cpu_addr),
    .dragon64 (dragon64),
    .ddrb2    (ddrb2),
    .portb2   (portb2),
    .device   (device_sel),  // also feeds the mux
    .alt_bank (alt_bank)
  );

  read_data_mux i_read_data_mux (
    .clk             (clk),
    .reset_n         (reset_n),
    .clk_ena         (clk_ena),
    .bus_sample      (bus_sample),
    .device          (device_sel),
    .alt_bank        (alt_bank),
    .ram_data        (ram_data),
    .rom_lo_data     (rom_lo_data),
    .rom_lo_alt_data (rom_lo_alt_data),
    .rom_hi_data     (rom_hi_data),
    .rom_hi_alt_data (rom_hi_alt_data),
    .cart_data       (cart_data),
    .pia0_data       (pia0_data),
    .pia1_data       (pia1_data),
    .acia_data       (acia_data),
    .io_data         (io_data),
    .cpu_din         (cpu_din)
  );

  joystick_dac_compare i_joystick_dac_compare (
    .clk          (clk),
    .reset_n      (reset_n),
    .joy_use_dpad (joy_use_dpad),
    .joy1         (joy1),
    .joy2         (joy2),
    .joya1        (joya1),
    .joya2        (joya2),
    .dac_data     (dac_data),
    .sela         (sela),
    .selb         (selb),
    .hilo         (hilo)
  );

endmodule

// ==== dv/bus_glue_checker.sv ====
// bus glue response checker
`timescale 1ns/1ps

module bus_glue_checker
  import coco_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       turbo,
  input  logic       clk_ena,
  input  device_e    device_sel,
  input  logic [7:0] cpu_din,
  input  logic       hilo,
  input  logic       check_req,   // expected values valid for one negedge
  input  int         test_id,
  input  device_e    exp_dev,
  input  logic [7:0] exp_din,
  input  logic       exp_hilo,
  output int         err_count,
  output int         test_count,
  output int         norm_gaps,   // clk_ena spacings measured, turbo low
  output int         turbo_gaps   // same, turbo high
);

  int   err_cnt = 0;
  int   test_cnt = 0;
  int   norm_cnt = 0;
  int   turbo_cnt = 0;
  int   gap;         // cycles since the last pulse
  int   want_gap;
  int   miss;        // mismatches in the current test
  logic have_pulse = 1'b0;
  logic gap_turbo;   // turbo when the interval opened
  logic gap_mixed;   // turbo moved inside the interval, skip it

  assign err_count  = err_cnt;
  assign test_count = test_cnt;
  assign norm_gaps  = norm_cnt;
  assign turbo_gaps = turbo_cnt;

  // everything sampled mid-cycle, well away from the driving edges
  always @(negedge clk)
  begin
    if (!reset_n)
    begin
      if (clk_ena !== 1'b0)
      begin
        $display("CHECK FAILED time=%0t clk_ena got %b expected 0", $time, clk_ena);
        err_cnt++;
      end
      have_pulse = 1'b0;  // first pulse after reset only opens an interval
    end
    else if (clk_ena)
    begin
      want_gap = gap_turbo ? CLK_DIV_TURBO : CLK_DIV_NORMAL;
      if (have_pulse && !gap_mixed)
      begin
        if (gap != want_gap)
        begin
          $display("CHECK FAILED time=%0t clk_ena spacing got %0d expected %0d",
                   $time, gap, want_gap);
          err_cnt++;
        end
        if (gap_turbo)
          turbo_cnt++;
        else
          norm_cnt++;
      end
      have_pulse = 1'b1;
      gap        = 1;
      gap_turbo  = turbo;  // used from the next rising edge on
      gap_mixed  = 1'b0;
    end
    else
    begin
      gap++;
      if (turbo !== gap_turbo)
        gap_mixed = 1'b1;
    end

    if (check_req)
    begin
      miss = 0;
      if (device_sel !== exp_dev)
      begin
        $display("CHECK FAILED time=%0t device_sel got %s expected %s",
                 $time, device_sel.name(), exp_dev.name());
        miss++;
      end
      if (cpu_din !== exp_din)
      begin
        $display("CHECK FAILED time=%0t cpu_din got %h expected %h", $time, cpu_din, exp_din);
        miss++;
      end
      if (hilo !== exp_hilo)
      begin
        $display("CHECK FAILED time=%0t hilo got %b expected %b", $time, hilo, exp_hilo);
        miss++;
      end
      err_cnt += miss;
      test_cnt++;
      $display("test %0d: %s", test_id, (miss == 0) ? "ok" : "mismatch");
    end
  end

endmodule

// ==== dv/tb_coco_bus_glue.sv ====
// coco bus glue testbench
`timescale 1ns/1ps

module tb_coco_bus_glue
  import coco_pkg::*;
();

  localparam int NUM_TESTS   = 34;
  localparam int ENA_TIMEOUT = 8;  // cycles, slowest divisor is 3

  // one stimulus row with its expected response
  typedef struct packed {
    logic [2:0]  mode;     // turbo, dragon64, bus_sample
    logic [15:0] addr;
    logic [1:0]  bank;     // ddrb2, portb2
    logic        dpad;
    logic [7:0]  pads;     // joy2, joy1
    logic [31:0] sticks;   // joya2, joya1
    logic [7:0]  sel_dac;  // selb, sela, dac_data
    device_e     dev;
    logic [7:0]  din;
    logic        hilo;
  } entry_t;

  logic        clk;
  logic        reset_n;
  logic        turbo;
  logic        dragon64;
  logic [15:0] cpu_addr;
  logic        ddrb2;
  logic        portb2;
  logic        bus_sample;
  logic        joy_use_dpad;
  logic [3:0]  joy1;
  logic [3:0]  joy2;
  logic [15:0] joya1;
  logic [15:0] joya2;
  logic [5:0]  dac_data;
  logic        sela;
  logic        selb;
  logic        clk_ena;
  device_e     device_sel;
  logic [7:0]  cpu_din;
  logic        hilo;

  logic        check_req;
  int          test_id;
  device_e     exp_dev;
  logic [7:0]  exp_din;
  logic        exp_hilo;
  int          err_count;
  int          test_count;
  int          norm_gaps;
  int          turbo_gaps;
  logic        seen;
  logic        timed_out;
  logic        no_spacing;
  entry_t      tests [NUM_TESTS];

  coco_bus_glue i_coco_bus_glue (
    .clk (clk), .reset_n (reset_n), .turbo (turbo), .dragon64 (dragon64),
    .cpu_addr (cpu_addr), .ddrb2 (ddrb2), .portb2 (portb2), .bus_sample (bus_sample),
    .ram_data (8'h11), .rom_lo_data (8'h22), .rom_lo_alt_data (8'h33),
    .rom_hi_data (8'h44), .rom_hi_alt_data (8'h55), .cart_data (8'h66),
    .pia0_data (8'h77), .pia1_data (8'h88), .acia_data (8'h99), .io_data (8'hAA),
    .joy_use_dpad (joy_use_dpad), .joy1 (joy1), .joy2 (joy2), .joya1 (joya1),
    .joya2 (joya2), .dac_data (dac_data), .sela (sela), .selb (selb),
    .clk_ena (clk_ena), .device_sel (device_sel), .cpu_din (cpu_din), .hilo (hilo)
  );

  bus_glue_checker i_bus_glue_checker (
    .clk (clk), .reset_n (reset_n), .turbo (turbo), .clk_ena (clk_ena),
    .device_sel (device_sel), .cpu_din (cpu_din), .hilo (hilo),
    .check_req (check_req), .test_id (test_id), .exp_dev (exp_dev),
    .exp_din (exp_din), .exp_hilo (exp_hilo), .err_count (err_count),
    .test_count (test_count), .norm_gaps (norm_gaps), .turbo_gaps (turbo_gaps)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 50 mhz
  end

  task automatic load_table();
    // mode    addr      bank   dpad  pads   sticks        sel_dac  dev  din  hilo
    tests[0]  = '{3'b000, 16'h0000, 2'b00, 1'b1, 8'h00, 32'h0, 8'h20, DEV_RAM, 8'hFF, 1'b1};
    tests[1]  = '{3'b001, 16'h0000, 2'b00, 1'b1, 8'h00, 32'h0, 8'h20, DEV_RAM, 8'h11, 1'b1};
    tests[2]  = '{3'b001, 16'h7FFF, 2'b00, 1'b1, 8'h00, 32'h0, 8'h21, DEV_RAM, 8'h11, 1'b0};
    tests[3]  = '{3'b001, 16'h8000, 2'b00, 1'b1, 8'h01, 32'h0, 8'h3C, DEV_ROM_LO, 8'h22, 1'b1};
    tests[4]  = '{3'b001, 16'h9FFF, 2'b00, 1'b1, 8'h02, 32'h0, 8'h05, DEV_ROM_LO, 8'h22, 1'b0};
    tests[5]  = '{3'b001, 16'hA000, 2'b00, 1'b1, 8'h04, 32'h0, 8'h7D, DEV_ROM_HI, 8'h44, 1'b0};
    tests[6]  = '{3'b001, 16'hBFFF, 2'b00, 1'b1, 8'h0C, 32'h0, 8'h44, DEV_ROM_HI, 8'h44, 1'b1};
    tests[7]  = '{3'b001, 16'hC000, 2'b00, 1'b1, 8'h30, 32'h0, 8'h85, DEV_CART, 8'h66, 1'b0};
    tests[8]  = '{3'b001, 16'hFEFF, 2'b00, 1'b1, 8'h40, 32'h0, 8'hFC, DEV_CART, 8'h66, 1'b1};
    tests[9]  = '{3'b001, 16'hFF00, 2'b00, 1'b1, 8'h00, 32'h0, 8'hE1, DEV_PIA0, 8'h77, 1'b0};
    tests[10] = '{3'b101, 16'hFF04, 2'b00, 1'b1, 8'h00, 32'h0, 8'h20, DEV_PIA0, 8'h77, 1'b1};
    tests[11] = '{3'b101, 16'hFF20, 2'b00, 1'b1, 8'h00, 32'h0, 8'h20, DEV_PIA1, 8'h88, 1'b1};
    tests[12] = '{3'b101, 16'hFF40, 2'b00, 1'b1, 8'h00, 32'h0, 8'h20, DEV_IO, 8'hAA, 1'b1};
    tests[13] = '{3'b101, 16'hFFC0, 2'b00, 1'b1, 8'h00, 32'h0, 8'h20, DEV_NONE, 8'hFF, 1'b1};
    tests[14] = '{3'b101, 16'hFFF0, 2'b00, 1'b1, 8'h00, 32'h0, 8'h20, DEV_ROM_HI, 8'h44, 1'b1};
    tests[15] = '{3'b101, 16'hFF60, 2'b00, 1'b1, 8'h00, 32'h0, 8'h20, DEV_NONE, 8'hFF, 1'b1};
    tests[16] = '{3'b101, 16'hFFFF, 2'b00, 1'b1, 8'h00, 32'h0, 8'h20, DEV_ROM_HI, 8'h44, 1'b1};
    tests[17] = '{3'b100, 16'h0000, 2'b00, 1'b1, 8'h00, 32'h0, 8'h20, DEV_RAM, 8'h44, 1'b1};
    tests[18] = '{3'b011, 16'hFF00, 2'b00, 1'b1, 8'h00, 32'h0, 8'h20, DEV_PIA0, 8'h77, 1'b1};
    tests[19] = '{3'b011, 16'hFF04, 2'b00, 1'b1, 8'h00, 32'h0, 8'h20, DEV_ACIA, 8'h99, 1'b1};
    tests[20] = '{3'b011, 16'h8000, 2'b10, 1'b1, 8'h00, 32'h0, 8'h20, DEV_ROM_LO, 8'h33, 1'b1};
    tests[21] = '{3'b111, 16'hA000, 2'b10, 1'b1, 8'h00, 32'h0, 8'h20, DEV_ROM_HI, 8'h55, 1'b1};
    tests[22] = '{3'b111, 16'hFFF0, 2'b10, 1'b1, 8'h00, 32'h0, 8'h20, DEV_ROM_HI, 8'h55, 1'b1};
    tests[23] = '{3'b111, 16'h8000, 2'b11, 1'b1, 8'h00, 32'h0, 8'h20, DEV_ROM_LO, 8'h22, 1'b1};
    tests[24] = '{3'b011, 16'hA000, 2'b00, 1'b1, 8'h00, 32'h0, 8'h20, DEV_ROM_HI, 8'h44, 1'b1};
    tests[25] = '{3'b011, 16'h9FFF, 2'b01, 1'b1, 8'h00, 32'h0, 8'h20, DEV_ROM_LO, 8'h22, 1'b1};
    tests[26] = '{3'b011, 16'h0000, 2'b10, 1'b1, 8'h00, 32'h0, 8'h20, DEV_RAM, 8'h11, 1'b1};
    tests[27] = '{3'b001, 16'h8000, 2'b10, 1'b1, 8'h00, 32'h0, 8'h20, DEV_ROM_LO, 8'h22, 1'b1};
    // analog sticks, x1 90 y1 60 x2 200 y2 1
    tests[28] = '{3'b001, 16'h0000, 2'b00, 1'b0, 8'h00, 32'hC8015A3C, 8'h16, DEV_RAM, 8'h11, 1'b1};
    tests[29] = '{3'b001, 16'h0000, 2'b00, 1'b0, 8'h00, 32'hC8015A3C, 8'h17, DEV_RAM, 8'h11, 1'b0};
    tests[30] = '{3'b001, 16'h0000, 2'b00, 1'b0, 8'h00, 32'hC8015A3C, 8'h4F, DEV_RAM, 8'h11, 1'b1};
    tests[31] = '{3'b001, 16'h0000, 2'b00, 1'b0, 8'h00, 32'hC8015A3C, 8'hB3, DEV_RAM, 8'h11, 1'b0};
    tests[32] = '{3'b001, 16'h0000, 2'b00, 1'b0, 8'h00, 32'hC8015A3C, 8'hC0, DEV_RAM, 8'h11, 1'b1};
    tests[33] = '{3'b001, 16'h0000, 2'b00, 1'b0, 8'h00, 32'hC8015A3C, 8'hC1, DEV_RAM, 8'h11, 1'b0};
  endtask

  task automatic drive_entry(input entry_t e);
    {turbo, dragon64, bus_sample} = e.mode;
    cpu_addr                      = e.addr;
    {ddrb2, portb2}               = e.bank;
    joy_use_dpad                  = e.dpad;
    {joy2, joy1}                  = e.pads;
    {joya2, joya1}                = e.sticks;
    {selb, sela, dac_data}        = e.sel_dac;
  endtask

  // next clk_ena pulse, seen mid-cycle so the following edge samples
  task automatic wait_enable(output logic found);
    int cycles;
    found  = 1'b0;
    cycles = 0;
    while (!found && cycles < ENA_TIMEOUT)
    begin
      @(negedge clk);
      found = clk_ena;
      cycles++;
    end
  endtask

  initial
  begin
    load_table();
    reset_n    = 1'b0;
    drive_entry('0);  // everything idle during reset
    check_req  = 1'b0;
    test_id    = 0;
    exp_dev    = DEV_NONE;
    exp_din    = OPEN_BUS;
    exp_hilo   = 1'b0;
    timed_out  = 1'b0;
    no_spacing = 1'b0;
    repeat (8) @(posedge clk);
    #2 reset_n = 1'b1;

    for (int i = 0; i < NUM_TESTS && !timed_out; i++)
    begin
      @(posedge clk);
      #2;
      check_req = 1'b0;
      drive_entry(tests[i]);
      wait_enable(seen);
      if (!seen)
      begin
        timed_out = 1'b1;
        $display("timeout: no clk_ena pulse within %0d cycles in test %0d", ENA_TIMEOUT, i);
      end
      else
      begin
        @(posedge clk);  // sample edge, cpu_din settles after it
        #2;
        test_id   = i;
        exp_dev   = tests[i].dev;
        exp_din   = tests[i].din;
        exp_hilo  = tests[i].hilo;
        check_req = 1'b1;
      end
    end
    @(posedge clk);
    #2 check_req = 1'b0;
    repeat (2) @(posedge clk);

    if (norm_gaps == 0 || turbo_gaps == 0)
    begin
      no_spacing = 1'b1;
      $display("clk_ena spacing was not measured with turbo both low and high");
    end
    $display("tests %0d of %0d, errors %0d, clk_ena spacings %0d normal %0d turbo",
             test_count, NUM_TESTS, err_count, norm_gaps, turbo_gaps);
    if (err_count == 0 && !timed_out && !no_spacing && test_count == NUM_TESTS)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== compile.f ====
design/coco_pkg.sv
design/clock_enable_gen.sv
design/address_decoder.sv
design/read_data_mux.sv
design/joystick_dac_compare.sv
design/coco_bus_glue.sv
dv/bus_glue_checker.sv
dv/tb_coco_bus_glue.sv

// ==== Makefile ====
# verilator flow for the coco bus glue testbench

VERILATOR ?= verilator
TOP       ?= tb_coco_bus_glue
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
